/* design/exec_lane.sv */
// single execution lane
`timescale 1ns/1ns
`default_nettype none

module exec_lane (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire logic               in_valid,
    input  pipe_pkg::issue_pkt_t    in_pkt,
    output logic                    ready,
    output logic                    res_valid,
    output pipe_pkg::wb_pkt_t       res_pkt,
    input  wire logic               grant
);

    logic                               ex_valid;
    pipe_pkg::issue_pkt_t               ex_pkt;
    logic [isa_pkg::XLEN-1:0]           alu_res;
    logic [isa_pkg::SHAMT_W-1:0]        shamt;
    logic                               wb_full;
    logic                               stall;

    // EX/WB holds its result until writeback takes it
    assign stall     = wb_full && !grant;
    assign ready     = !ex_valid || !stall;
    assign res_valid = wb_full;

    //////////////////////////////////////////////////
    // EX operand register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid <= 1'b0;
        end else if (ready) begin
            ex_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ready && in_valid) begin
            ex_pkt <= in_pkt;
        end
    end

    //////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////

    assign shamt = ex_pkt.src_b[isa_pkg::SHAMT_W-1:0];

    // results truncate to XLEN by assignment width
    always_comb begin
        case (ex_pkt.op)
            isa_pkg::OP_ADD: alu_res = ex_pkt.src_a + ex_pkt.src_b;
            isa_pkg::OP_SUB: alu_res = ex_pkt.src_a - ex_pkt.src_b;
            isa_pkg::OP_AND: alu_res = ex_pkt.src_a & ex_pkt.src_b;
            isa_pkg::OP_OR:  alu_res = ex_pkt.src_a | ex_pkt.src_b;
            isa_pkg::OP_XOR: alu_res = ex_pkt.src_a ^ ex_pkt.src_b;
            isa_pkg::OP_SHL: alu_res = ex_pkt.src_a << shamt;
            isa_pkg::OP_SHR: alu_res = ex_pkt.src_a >> shamt;
            isa_pkg::OP_MUL: alu_res = ex_pkt.src_a * ex_pkt.src_b;
            default:         alu_res = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // EX/WB result register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_full <= 1'b0;
        end else if (!stall) begin
            wb_full <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && ex_valid) begin
            res_pkt.data    <= alu_res;
            res_pkt.phy_dst <= ex_pkt.phy_dst;
            res_pkt.rob_idx <= ex_pkt.rob_idx;
            res_pkt.reg_wrt <= ex_pkt.reg_wrt;
        end
    end

endmodule

`default_nettype wire

/* design/exec_wb_top.sv */
// execute to writeback subsystem
`timescale 1ns/1ns
`default_nettype none

module exec_wb_top #(
    parameter int NUM_LANES = 4
) (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire logic               issue_valid,
    input  pipe_pkg::issue_pkt_t    issue_pkt,
    output logic                    issue_stall,
    output logic                    wb_valid,
    output pipe_pkg::wb_pkt_t       wb_pkt
);

    logic [NUM_LANES-1:0]               lane_ready;
    logic [NUM_LANES-1:0]               lane_valid;
    pipe_pkg::issue_pkt_t               lane_pkt;
    logic [NUM_LANES-1:0]               res_valid;
    pipe_pkg::wb_pkt_t [NUM_LANES-1:0]  res_pkt;
    logic [NUM_LANES-1:0]               grant;

    issue_dispatch #(
        .NUM_LANES   (NUM_LANES)
    ) u_dispatch (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .issue_pkt   (issue_pkt),
        .issue_stall (issue_stall),
        .lane_ready  (lane_ready),
        .lane_valid  (lane_valid),
        .lane_pkt    (lane_pkt)
    );

    // lanes share the dispatch packet, lane_valid picks one
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        exec_lane u_lane (
            .clk       (clk),
            .arst_n    (arst_n),
            .in_valid  (lane_valid[i]),
            .in_pkt    (lane_pkt),
            .ready     (lane_ready[i]),
            .res_valid (res_valid[i]),
            .res_pkt   (res_pkt[i]),
            .grant     (grant[i])
        );
    end

    wb_arbiter #(
        .NUM_LANES (NUM_LANES)
    ) u_arbiter (
        .clk       (clk),
        .arst_n    (arst_n),
        .res_valid (res_valid),
        .res_pkt   (res_pkt),
        .grant     (grant),
        .wb_valid  (wb_valid),
        .wb_pkt    (wb_pkt)
    );

endmodule

`default_nettype wire

/* design/isa_pkg.sv */
// execute datapath widths and opcodes
`default_nettype none

package isa_pkg;

    // data width of operands and results
    parameter int XLEN = 16;

    // physical register and reorder buffer index width
    parameter int TAG_W = 6;

    // opcode field width
    parameter int OP_W = 3;

    // shifts only look at the low bits of operand b
    parameter int SHAMT_W = 4;

    // add, sub and mul keep the low XLEN bits; logic ops are bitwise
    typedef enum logic [OP_W-1:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SHL = 3'd5,
        OP_SHR = 3'd6,
        OP_MUL = 3'd7
    } op_e;

endpackage

`default_nettype wire

/* design/issue_dispatch.sv */
// issue register and lane dispatch
`timescale 1ns/1ns
`default_nettype none

module issue_dispatch #(
    parameter int NUM_LANES = 4
) (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire logic                   issue_valid,
    input  pipe_pkg::issue_pkt_t        issue_pkt,
    output logic                        issue_stall,
    input  wire logic [NUM_LANES-1:0]   lane_ready,
    output logic [NUM_LANES-1:0]        lane_valid,
    output pipe_pkg::issue_pkt_t        lane_pkt
);

    logic                   hold_full;
    pipe_pkg::issue_pkt_t   hold_pkt;
    logic [NUM_LANES-1:0]   pick;
    logic                   found;
    logic                   any_ready;
    logic                   accept;

    // lowest ready lane wins
    always_comb begin
        pick  = '0;
        found = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (lane_ready[i] && !found) begin
                pick[i] = 1'b1;
                found   = 1'b1;
            end
        end
    end

    assign any_ready   = |lane_ready;
    assign issue_stall = hold_full && !any_ready;
    assign accept      = issue_valid && !issue_stall;
    assign lane_valid  = hold_full ? pick : '0;
    assign lane_pkt    = hold_pkt;

    // release and refill can happen in the same cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hold_full <= 1'b0;
        end else if (accept) begin
            hold_full <= 1'b1;
        end else if (hold_full && any_ready) begin
            hold_full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            hold_pkt <= issue_pkt;
        end
    end

endmodule

`default_nettype wire

/* design/pipe_pkg.sv */
// stage-to-stage packets
`default_nettype none

package pipe_pkg;

    //////////////////////////////////////////////////
    // issue side
    //////////////////////////////////////////////////

    // operands are already read from the register file
    typedef struct packed {
        isa_pkg::op_e                  op;
        logic [isa_pkg::XLEN-1:0]      src_a;
        logic [isa_pkg::XLEN-1:0]      src_b;
        logic [isa_pkg::TAG_W-1:0]     phy_dst;
        logic [isa_pkg::TAG_W-1:0]     rob_idx;
        logic                          reg_wrt;
    } issue_pkt_t;

    //////////////////////////////////////////////////
    // writeback side
    //////////////////////////////////////////////////

    // rob_idx doubles as the done index for the reorder buffer
    typedef struct packed {
        logic [isa_pkg::XLEN-1:0]      data;
        logic [isa_pkg::TAG_W-1:0]     phy_dst;
        logic [isa_pkg::TAG_W-1:0]     rob_idx;
        logic                          reg_wrt;
    } wb_pkt_t;

endpackage

`default_nettype wire

/* design/wb_arbiter.sv */
// round-robin writeback arbiter
`timescale 1ns/1ns
`default_nettype none

module wb_arbiter #(
    parameter int NUM_LANES = 4
) (
    input  wire logic                           clk,
    input  wire logic                           arst_n,
    input  wire logic [NUM_LANES-1:0]           res_valid,
    input  pipe_pkg::wb_pkt_t [NUM_LANES-1:0]   res_pkt,
    output logic [NUM_LANES-1:0]                grant,
    output logic                                wb_valid,
    output pipe_pkg::wb_pkt_t                   wb_pkt
);

    localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    // ptr is the first lane looked at, one past the last grant
    logic [PTR_W-1:0]   ptr;
    logic [PTR_W-1:0]   sel;
    logic               found;

    //////////////////////////////////////////////////
    // search from ptr with wraparound
    //////////////////////////////////////////////////

    always_comb begin
        int idx;
        grant = '0;
        sel   = ptr;
        found = 1'b0;
        for (int k = 0; k < NUM_LANES; k++) begin
            idx = (int'(ptr) + k) % NUM_LANES;
            if (!found && res_valid[idx]) begin
                grant[idx] = 1'b1;
                sel        = PTR_W'(idx);
                found      = 1'b1;
            end
        end
    end

    // writeback port, one result per cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
            ptr      <= '0;
        end else begin
            wb_valid <= found;
            if (found) begin
                ptr <= (int'(sel) == NUM_LANES - 1) ? '0 : sel + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (found) begin
            wb_pkt <= res_pkt[sel];
        end
    end

endmodule

`default_nettype wire

/* filelist.f */
design/isa_pkg.sv
design/pipe_pkg.sv
design/issue_dispatch.sv
design/exec_lane.sv
design/wb_arbiter.sv
design/exec_wb_top.sv
sim/exec_wb_chk.sv
sim/wb_monitor.sv
sim/tb_exec_wb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_exec_wb -f filelist.f -o sim_exec_wb

./obj_dir/sim_exec_wb | tee sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

/* sim/exec_wb_chk.sv */
// writeback arbiter assertions
`timescale 1ns/1ns
`default_nettype none

module exec_wb_chk #(
    parameter int NUM_LANES = 4
) (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire logic [NUM_LANES-1:0]   res_valid,
    input  wire logic [NUM_LANES-1:0]   grant,
    input  wire logic                   wb_valid
);

    a_grant_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(grant))
        else $error("more than one lane granted in the same cycle");

    // a grant must point at a finished result
    a_grant_valid: assert property (@(posedge clk) disable iff (!arst_n)
        (grant & ~res_valid) == '0)
        else $error("grant given to a lane without a valid result");

    a_reset_idle: assert property (@(posedge clk) !arst_n |-> !wb_valid)
        else $error("writeback valid while reset is asserted");

endmodule

bind wb_arbiter exec_wb_chk #(
    .NUM_LANES (NUM_LANES)
) u_chk (
    .clk       (clk),
    .arst_n    (arst_n),
    .res_valid (res_valid),
    .grant     (grant),
    .wb_valid  (wb_valid)
);

`default_nettype wire

/* sim/exec_wb_vectors.txt */
// columns: op src_a src_b phy_dst rob_idx reg_wrt expected (hex)
// op: 0 add 1 sub 2 and 3 or 4 xor 5 shl 6 shr 7 mul
0 1234 4321 05 00 1 5555
0 ffff 0002 06 01 1 0001
1 0005 0007 07 02 1 fffe
1 8000 0001 08 03 0 7fff
2 f0f0 3c3c 09 04 1 3030
3 f0f0 0f0f 0a 05 1 ffff
4 aaaa ffff 0b 06 1 5555
5 0001 000f 0c 07 1 8000
5 1234 0014 0d 08 1 2340
6 8000 000f 0e 09 1 0001
6 f00d 0013 0f 0a 0 1e01
7 0100 0100 10 0b 1 0000
7 1234 0003 11 0c 1 369c
7 ffff ffff 12 0d 1 0001
0 7fff 0001 13 0e 1 8000
1 0000 0001 14 0f 1 ffff
4 1234 1234 15 10 0 0000
7 00ff 0101 16 11 1 ffff

/* sim/tb_exec_wb.sv */
// execute to writeback testbench
`timescale 1ns/1ns
`default_nettype none

module tb_exec_wb;

    localparam int NUM_LANES = 4;
    localparam int NUM_VEC   = 18;
    localparam int FIELDS    = 7;
    localparam int DEPTH     = 2 ** isa_pkg::TAG_W;
    // from this vector on, issues go back to back
    localparam int BURST_AT  = 6;
    localparam int TIMEOUT   = 50;

    logic                   clk;
    logic                   arst_n;
    logic                   issue_valid;
    pipe_pkg::issue_pkt_t   issue_pkt;
    logic                   issue_stall;
    logic                   wb_valid;
    pipe_pkg::wb_pkt_t      wb_pkt;
    logic [15:0]            vec_mem [NUM_VEC*FIELDS];
    pipe_pkg::wb_pkt_t      exp_tab [DEPTH];
    int                     errors;
    int                     pending;
    int                     stall_cycles;
    int                     timeouts;

    exec_wb_top #(
        .NUM_LANES   (NUM_LANES)
    ) u_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .issue_pkt   (issue_pkt),
        .issue_stall (issue_stall),
        .wb_valid    (wb_valid),
        .wb_pkt      (wb_pkt)
    );

    wb_monitor #(
        .DEPTH        (DEPTH)
    ) u_mon (
        .clk          (clk),
        .arst_n       (arst_n),
        .issue_valid  (issue_valid),
        .issue_pkt    (issue_pkt),
        .issue_stall  (issue_stall),
        .wb_valid     (wb_valid),
        .wb_pkt       (wb_pkt),
        .exp_tab      (exp_tab),
        .errors       (errors),
        .pending      (pending),
        .stall_cycles (stall_cycles)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // vector handling
    //////////////////////////////////////////////////

    // expected table is keyed by rob_idx
    task automatic load_vectors();
        int base;
        int idx;
        $readmemh("sim/exec_wb_vectors.txt", vec_mem);
        for (int i = 0; i < DEPTH; i++) begin
            exp_tab[i] = '0;
        end
        for (int n = 0; n < NUM_VEC; n++) begin
            base = n * FIELDS;
            idx  = int'(vec_mem[base+4][5:0]);
            exp_tab[idx].data    = vec_mem[base+6];
            exp_tab[idx].phy_dst = vec_mem[base+3][5:0];
            exp_tab[idx].rob_idx = vec_mem[base+4][5:0];
            exp_tab[idx].reg_wrt = vec_mem[base+5][0];
        end
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic issue_vector(input int n);
        int base;
        int waited;
        base = n * FIELDS;
        issue_valid       = 1'b1;
        issue_pkt.op      = isa_pkg::op_e'(vec_mem[base][2:0]);
        issue_pkt.src_a   = vec_mem[base+1];
        issue_pkt.src_b   = vec_mem[base+2];
        issue_pkt.phy_dst = vec_mem[base+3][5:0];
        issue_pkt.rob_idx = vec_mem[base+4][5:0];
        issue_pkt.reg_wrt = vec_mem[base+5][0];
        waited = 0;
        while (issue_stall && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (issue_stall) begin
            $display("vector %0d was held off by issue_stall for %0d cycles", n, TIMEOUT);
            timeouts++;
        end
        @(negedge clk);
    endtask

    initial begin
        int gap;
        int waited;
        void'($urandom(32'h93df_ab6b));
        arst_n      = 1'b0;
        issue_valid = 1'b0;
        issue_pkt   = '0;
        timeouts    = 0;
        load_vectors();
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        // idle window, nothing may come out
        repeat (6) @(negedge clk);
        for (int n = 0; n < NUM_VEC; n++) begin
            issue_vector(n);
            if (n < BURST_AT) begin
                issue_valid = 1'b0;
                gap = $urandom_range(3, 0);
                repeat (gap) @(negedge clk);
            end
        end
        issue_valid = 1'b0;
        waited = 0;
        while (pending != 0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (pending != 0) begin
            $display("drain timed out with writebacks still outstanding");
            timeouts++;
        end
        $display("errors=%0d missing=%0d timeouts=%0d stall_cycles=%0d",
                 errors, pending, timeouts, stall_cycles);
        if (errors == 0 && pending == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/wb_monitor.sv */
// writeback scoreboard
`timescale 1ns/1ns
`default_nettype none

module wb_monitor #(
    parameter int DEPTH = 64
) (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire logic               issue_valid,
    input  pipe_pkg::issue_pkt_t    issue_pkt,
    input  wire logic               issue_stall,
    input  wire logic               wb_valid,
    input  pipe_pkg::wb_pkt_t       wb_pkt,
    input  pipe_pkg::wb_pkt_t       exp_tab [DEPTH],
    output int                      errors,
    output int                      pending,
    output int                      stall_cycles
);

    // one flag and accept cycle per rob index
    bit     in_flight [DEPTH];
    int     accept_cyc [DEPTH];
    int     cyc;
    bit     issued_any;

    always @(posedge clk) begin
        int idx;
        if (!arst_n) begin
            cyc          = 0;
            issued_any   = 1'b0;
            errors       = 0;
            pending      = 0;
            stall_cycles = 0;
            for (int i = 0; i < DEPTH; i++) begin
                in_flight[i] = 1'b0;
            end
        end else begin
            cyc++;
            if (issue_stall) begin
                stall_cycles++;
                if (!issued_any) begin
                    $display("issue_stall went high before anything was issued");
                    errors++;
                end
            end

            //////////////////////////////////////////////////
            // writeback side, checked before new accepts
            //////////////////////////////////////////////////
            if (wb_valid) begin
                idx = int'(wb_pkt.rob_idx);
                if ($isunknown(wb_pkt)) begin
                    $display("[FAIL] %0t: writeback packet has unknown bits", $time);
                    errors++;
                end else if (!in_flight[idx]) begin
                    $display("[FAIL] %0t: rob %0d written back but not in flight", $time, idx);
                    errors++;
                end else begin
                    in_flight[idx] = 1'b0;
                    pending--;
                    if (wb_pkt.data !== exp_tab[idx].data) begin
                        $display("[FAIL] %0t: rob %0d data %h, expected %h", $time, idx,
                                 wb_pkt.data, exp_tab[idx].data);
                        errors++;
                    end
                    if (wb_pkt.phy_dst !== exp_tab[idx].phy_dst ||
                        wb_pkt.reg_wrt !== exp_tab[idx].reg_wrt) begin
                        $display("[FAIL] %0t: rob %0d dst %0d wrt %b, expected dst %0d wrt %b",
                                 $time, idx, wb_pkt.phy_dst, wb_pkt.reg_wrt,
                                 exp_tab[idx].phy_dst, exp_tab[idx].reg_wrt);
                        errors++;
                    end
                    if (cyc - accept_cyc[idx] < 4) begin
                        $display("[FAIL] %0t: rob %0d back after %0d cycles, minimum 4",
                                 $time, idx, cyc - accept_cyc[idx]);
                        errors++;
                    end
                end
            end

            // accept edge
            if (issue_valid && !issue_stall) begin
                idx = int'(issue_pkt.rob_idx);
                if (in_flight[idx]) begin
                    $display("rob %0d was issued again while still in flight", idx);
                    errors++;
                end
                in_flight[idx]  = 1'b1;
                accept_cyc[idx] = cyc;
                pending++;
                issued_any      = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire
